/* src/cpu_pkg.sv */
package cpu_pkg;

  localparam int DATA_W = 8;
  localparam int ADDR_W = 16;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Opcode in [7:4], destination in [3:2], source in [1:0]
  typedef logic [7:0] instr_t;
  typedef logic [1:0] reg_idx_t;

  // Negative in bit 1, carry in bit 0
  typedef logic [1:0] flags_t;

  localparam int FLAG_C = 0;
  localparam int FLAG_N = 1;

  localparam reg_idx_t REG_A = 2'd0;
  localparam reg_idx_t REG_B = 2'd1;
  localparam reg_idx_t REG_C = 2'd2;
  localparam reg_idx_t REG_D = 2'd3;

  localparam addr_t RESET_PC = 16'h0000;

  // Codes 12 to 14 are unassigned and execute as NOP
  typedef enum logic [3:0] {
    OP_NOP = 4'd0,
    OP_LDI = 4'd1,
    OP_MOV = 4'd2,
    OP_ADD = 4'd3,
    OP_ADC = 4'd4,
    OP_SUB = 4'd5,
    OP_AND = 4'd6,
    OP_OR  = 4'd7,
    OP_XOR = 4'd8,
    OP_JMP = 4'd9,
    OP_JC  = 4'd10,
    OP_JN  = 4'd11,
    OP_HLT = 4'd15
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_ADC,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS
  } alu_op_e;

  // Total bytes of an instruction, opcode byte included
  function automatic logic [1:0] instr_len(input instr_t instr);
    case (opcode_e'(instr[7:4]))
      OP_LDI: return 2'd2;
      OP_JMP, OP_JC, OP_JN: return 2'd3;
      default: return 2'd1;
    endcase
  endfunction

endpackage

/* src/fetch_if.sv */
`timescale 1ns/1ps

interface fetch_if;
  import cpu_pkg::*;

  // Forward path, one assembled instruction
  logic   valid;
  instr_t instr;
  addr_t  operand;
  addr_t  next_pc;

  // Backward path from the execute side
  logic   ready;
  logic   redirect;
  addr_t  redirect_pc;

  modport fetch (output valid, instr, operand, next_pc, input ready, redirect, redirect_pc);
  modport exec (input valid, instr, operand, next_pc, output ready, redirect, redirect_pc);

endinterface

/* src/reg_if.sv */
`timescale 1ns/1ps

interface reg_if;
  import cpu_pkg::*;

  reg_idx_t dst_idx;
  reg_idx_t src_idx;
  logic     wr_en;
  data_t    wr_data;
  logic     flags_wr_en;
  flags_t   flags_wr_data;

  // Combinational read data
  data_t    dst_data;
  data_t    src_data;
  flags_t   flags;

  modport exec (
    output dst_idx, src_idx, wr_en, wr_data, flags_wr_en, flags_wr_data,
    input  dst_data, src_data, flags
  );
  modport regs (
    input  dst_idx, src_idx, wr_en, wr_data, flags_wr_en, flags_wr_data,
    output dst_data, src_data, flags
  );

endinterface

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::alu_op_e op,
  input  cpu_pkg::data_t   lhs,
  input  cpu_pkg::data_t   rhs,
  input  logic             carry_in,
  output cpu_pkg::data_t   result,
  output cpu_pkg::flags_t  flags_out
);
  import cpu_pkg::*;

  // Bit 8 carries the carry-out
  logic [8:0] sum;

  always_comb begin
    case (op)
      ALU_ADD:  sum = {1'b0, lhs} + {1'b0, rhs};
      ALU_ADC:  sum = {1'b0, lhs} + {1'b0, rhs} + {8'd0, carry_in};
      // Carry set means no borrow, lhs >= rhs
      ALU_SUB:  sum = {1'b0, lhs} + {1'b0, ~rhs} + 9'd1;
      ALU_AND:  sum = {1'b0, lhs & rhs};
      ALU_OR:   sum = {1'b0, lhs | rhs};
      ALU_XOR:  sum = {1'b0, lhs ^ rhs};
      ALU_PASS: sum = {1'b0, rhs};
      default:  sum = '0;
    endcase
  end

  assign result = sum[7:0];

  always_comb begin
    flags_out         = '0;
    flags_out[FLAG_C] = sum[8];
    flags_out[FLAG_N] = sum[7];
  end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic            clk,
  input  logic            rst_n,
  reg_if.regs             regs,
  output cpu_pkg::data_t  reg_a,
  output cpu_pkg::data_t  reg_b,
  output cpu_pkg::data_t  reg_c,
  output cpu_pkg::data_t  reg_d,
  output cpu_pkg::flags_t flags
);
  import cpu_pkg::*;

  data_t  gpr [4];
  flags_t flags_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gpr     <= '{default: '0};
      flags_q <= '0;
    end else begin
      if (regs.wr_en) begin
        gpr[regs.dst_idx] <= regs.wr_data;
      end
      if (regs.flags_wr_en) begin
        flags_q <= regs.flags_wr_data;
      end
    end
  end

  // Two read ports for the ALU operands
  assign regs.dst_data = gpr[regs.dst_idx];
  assign regs.src_data = gpr[regs.src_idx];
  assign regs.flags    = flags_q;

  assign reg_a = gpr[REG_A];
  assign reg_b = gpr[REG_B];
  assign reg_c = gpr[REG_C];
  assign reg_d = gpr[REG_D];
  assign flags = flags_q;

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
  input  logic           clk,
  input  logic           rst_n,
  output logic           mem_req,
  output cpu_pkg::addr_t mem_addr,
  input  cpu_pkg::data_t mem_data,
  input  logic           mem_ack,
  fetch_if.fetch         fetch
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT_ACK_LOW,
    ST_HOLD
  } fetch_state_e;

  fetch_state_e state;
  addr_t        fetch_addr;
  logic [1:0]   byte_cnt;
  instr_t       instr_r;
  addr_t        operand_r;
  logic         capture;

  // Every acknowledged byte belongs to the instruction being assembled
  assign capture = (state == ST_REQ) && mem_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      fetch_addr <= RESET_PC;
      byte_cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (!mem_ack) begin
            state <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (mem_ack) begin
            state      <= ST_WAIT_ACK_LOW;
            fetch_addr <= fetch_addr + 16'd1;
            byte_cnt   <= byte_cnt + 2'd1;
          end
        end
        ST_WAIT_ACK_LOW: begin
          if (!mem_ack) begin
            state <= (byte_cnt == instr_len(instr_r)) ? ST_HOLD : ST_REQ;
          end
        end
        ST_HOLD: begin
          // Next instruction starts right after the transfer
          if (fetch.ready) begin
            state    <= ST_REQ;
            byte_cnt <= '0;
          end
        end
        default: state <= ST_IDLE;
      endcase

      // A redirect only comes with a transfer out of hold, no byte is in flight
      if (fetch.redirect) begin
        fetch_addr <= fetch.redirect_pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      case (byte_cnt)
        2'd0:    instr_r <= mem_data;
        2'd1:    operand_r[7:0] <= mem_data;
        default: operand_r[15:8] <= mem_data;
      endcase
    end
  end

  assign mem_req       = (state == ST_REQ);
  assign mem_addr      = fetch_addr;
  assign fetch.valid   = (state == ST_HOLD);
  assign fetch.instr   = instr_r;
  assign fetch.operand = operand_r;
  assign fetch.next_pc = fetch_addr;

endmodule

/* src/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
  input  logic             clk,
  input  logic             rst_n,
  fetch_if.exec            fetch,
  reg_if.exec              regs,
  output cpu_pkg::alu_op_e alu_op,
  output cpu_pkg::data_t   alu_lhs,
  output cpu_pkg::data_t   alu_rhs,
  output logic             alu_carry_in,
  input  cpu_pkg::data_t   alu_result,
  input  cpu_pkg::flags_t  alu_flags,
  output cpu_pkg::addr_t   pc,
  output logic             halt
);
  import cpu_pkg::*;

  opcode_e opcode;
  logic    fire;
  logic    taken;

  assign opcode = opcode_e'(fetch.instr[7:4]);
  assign fire   = fetch.valid && fetch.ready;

  assign regs.dst_idx       = fetch.instr[3:2];
  assign regs.src_idx       = fetch.instr[1:0];
  assign regs.flags_wr_data = alu_flags;
  assign alu_lhs            = regs.dst_data;
  assign alu_rhs            = regs.src_data;
  assign alu_carry_in       = regs.flags[FLAG_C];

  always_comb begin
    regs.wr_en       = 1'b0;
    regs.flags_wr_en = 1'b0;
    regs.wr_data     = alu_result;
    alu_op           = ALU_PASS;
    taken            = 1'b0;
    case (opcode)
      OP_LDI: begin
        regs.wr_en   = fire;
        regs.wr_data = fetch.operand[7:0];
      end
      // MOV goes through the ALU as PASS
      OP_MOV: regs.wr_en = fire;
      OP_ADD, OP_ADC, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
        regs.wr_en       = fire;
        regs.flags_wr_en = fire;
        case (opcode)
          OP_ADD:  alu_op = ALU_ADD;
          OP_ADC:  alu_op = ALU_ADC;
          OP_SUB:  alu_op = ALU_SUB;
          OP_AND:  alu_op = ALU_AND;
          OP_OR:   alu_op = ALU_OR;
          default: alu_op = ALU_XOR;
        endcase
      end
      OP_JMP: taken = 1'b1;
      OP_JC:  taken = regs.flags[FLAG_C];
      OP_JN:  taken = regs.flags[FLAG_N];
      default: ;
    endcase
  end

  // Redirect lands on the same edge as the jump itself
  assign fetch.redirect    = fire && taken;
  assign fetch.redirect_pc = fetch.operand;
  assign fetch.ready       = !halt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc   <= RESET_PC;
      halt <= 1'b0;
    end else if (fire) begin
      pc <= taken ? fetch.operand : fetch.next_pc;
      if (opcode == OP_HLT) begin
        halt <= 1'b1;
      end
    end
  end

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
  input  logic            clk,
  input  logic            rst_n,
  output logic            mem_req,
  output cpu_pkg::addr_t  mem_addr,
  input  cpu_pkg::data_t  mem_data,
  input  logic            mem_ack,
  output cpu_pkg::data_t  reg_a,
  output cpu_pkg::data_t  reg_b,
  output cpu_pkg::data_t  reg_c,
  output cpu_pkg::data_t  reg_d,
  output cpu_pkg::flags_t flags,
  output cpu_pkg::addr_t  pc,
  output logic            halt
);
  import cpu_pkg::*;

  alu_op_e alu_op;
  data_t   alu_lhs;
  data_t   alu_rhs;
  logic    alu_carry_in;
  data_t   alu_result;
  flags_t  alu_flags;

  fetch_if u_fetch_if ();
  reg_if   u_reg_if ();

  fetch_unit u_fetch_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_data (mem_data),
    .mem_ack  (mem_ack),
    .fetch    (u_fetch_if.fetch)
  );

  exec_unit u_exec_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch        (u_fetch_if.exec),
    .regs         (u_reg_if.exec),
    .alu_op       (alu_op),
    .alu_lhs      (alu_lhs),
    .alu_rhs      (alu_rhs),
    .alu_carry_in (alu_carry_in),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .pc           (pc),
    .halt         (halt)
  );

  alu u_alu (
    .op        (alu_op),
    .lhs       (alu_lhs),
    .rhs       (alu_rhs),
    .carry_in  (alu_carry_in),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  reg_file u_reg_file (
    .clk   (clk),
    .rst_n (rst_n),
    .regs  (u_reg_if.regs),
    .reg_a (reg_a),
    .reg_b (reg_b),
    .reg_c (reg_c),
    .reg_d (reg_d),
    .flags (flags)
  );

endmodule

/* tests/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int CYCLE_LIMIT = 400;
  localparam int NUM_RUNS    = 13;
  // Every run also spends a few cycles in reset
  localparam int WATCHDOG_NS = NUM_RUNS * (CYCLE_LIMIT + 8) * CLK_PERIOD + 1000;

  logic   clk;
  logic   rst_n;
  logic   mem_req;
  addr_t  mem_addr;
  data_t  mem_data;
  logic   mem_ack;
  data_t  reg_a;
  data_t  reg_b;
  data_t  reg_c;
  data_t  reg_d;
  flags_t flags;
  addr_t  pc;
  logic   halt;

  data_t  mem [65536];
  data_t  program_q [$];

  cpu_top u_cpu_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_data (mem_data),
    .mem_ack  (mem_ack),
    .reg_a    (reg_a),
    .reg_b    (reg_b),
    .reg_c    (reg_c),
    .reg_d    (reg_d),
    .flags    (flags),
    .pc       (pc),
    .halt     (halt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Program memory, four-phase slave with 0 to 3 cycles of ack delay
  // Port inputs are sampled at the falling edge, where they are stable
  initial begin
    int unsigned wait_cycles;
    logic        pending;
    logic        rst_seen;
    logic        req_seen;
    addr_t       addr_seen;
    addr_t       req_addr;
    mem_ack     = 1'b0;
    mem_data    = '0;
    pending     = 1'b0;
    wait_cycles = 0;
    req_addr    = '0;
    forever begin
      @(negedge clk);
      rst_seen  = rst_n;
      req_seen  = mem_req;
      addr_seen = mem_addr;
      @(posedge clk);
      #1;
      if (!rst_seen) begin
        mem_ack = 1'b0;
        pending = 1'b0;
      end else if (mem_ack) begin
        if (!req_seen) begin
          mem_ack = 1'b0;
        end
      end else if (req_seen) begin
        if (!pending) begin
          pending     = 1'b1;
          req_addr    = addr_seen;
          wait_cycles = $urandom % 4;
        end
        // Address must not move while req waits for ack
        check_addr("mem_addr during request", req_addr, addr_seen);
        if (wait_cycles == 0) begin
          mem_data = mem[addr_seen];
          mem_ack  = 1'b1;
          pending  = 1'b0;
        end else begin
          wait_cycles--;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests completed");
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped by watchdog");
  end

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_flags(input string name, input flags_t exp, input flags_t act);
    if (act !== exp) begin
      $display("ERR %s: expected %b, actual %b", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "flags mismatch");
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s: expected %b, actual %b", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "control bit mismatch");
    end
  endtask

  function automatic void emit_op(opcode_e op, reg_idx_t dst, reg_idx_t src);
    program_q.push_back({op, dst, src});
  endfunction

  function automatic void emit_ldi(reg_idx_t dst, data_t value);
    emit_op(OP_LDI, dst, REG_A);
    program_q.push_back(value);
  endfunction

  // Target bytes are left empty, returns where they sit
  function automatic int emit_jump(opcode_e op);
    int pos;
    emit_op(op, REG_A, REG_A);
    pos = program_q.size();
    program_q.push_back(8'h00);
    program_q.push_back(8'h00);
    return pos;
  endfunction

  function automatic void patch_target(int pos, addr_t target);
    program_q[pos]     = target[7:0];
    program_q[pos + 1] = target[15:8];
  endfunction

  function automatic addr_t here();
    return addr_t'(program_q.size());
  endfunction

  // {carry, sum} of two bytes and a carry in
  function automatic logic [8:0] add_bytes(data_t lhs, data_t rhs, logic cin);
    int total;
    total = int'(lhs) + int'(rhs) + (cin ? 1 : 0);
    return total[8:0];
  endfunction

  task automatic load_program();
    int i;
    // Background bytes mix both address halves
    for (i = 0; i < 65536; i++) begin
      mem[i] = data_t'(i[15:8] ^ i[7:0] ^ 8'h3C);
    end
    foreach (program_q[k]) begin
      mem[k] = program_q[k];
    end
  endtask

  task automatic apply_reset(input string name);
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_bit({name, " reset halt"}, 1'b0, halt);
    check_bit({name, " reset mem_req"}, 1'b0, mem_req);
    check_data({name, " reset reg_a"}, 8'h00, reg_a);
    check_data({name, " reset reg_b"}, 8'h00, reg_b);
    check_data({name, " reset reg_c"}, 8'h00, reg_c);
    check_data({name, " reset reg_d"}, 8'h00, reg_d);
    check_flags({name, " reset flags"}, 2'b00, flags);
    check_addr({name, " reset pc"}, RESET_PC, pc);
    @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic run_program(input string name);
    int cycles;
    load_program();
    apply_reset(name);
    cycles = 0;
    while (!halt && cycles < CYCLE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("%s: CPU did not halt within %0d cycles", name, CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $fatal(1, "halt timeout");
    end
  endtask

  task automatic test_ldi_mov();
    addr_t end_pc;
    program_q.delete();
    emit_ldi(REG_A, 8'h12);
    emit_ldi(REG_B, 8'h34);
    emit_ldi(REG_C, 8'hA5);
    emit_op(OP_MOV, REG_D, REG_B);
    emit_op(OP_MOV, REG_B, REG_A);
    emit_op(OP_HLT, REG_A, REG_A);
    end_pc = here();
    run_program("ldi_mov");
    check_data("ldi_mov reg_a", 8'h12, reg_a);
    check_data("ldi_mov reg_b", 8'h12, reg_b);
    check_data("ldi_mov reg_c", 8'hA5, reg_c);
    check_data("ldi_mov reg_d", 8'h34, reg_d);
    check_flags("ldi_mov flags", 2'b00, flags);
    check_addr("ldi_mov pc", end_pc, pc);
  endtask

  task automatic test_add_adc();
    int         run;
    data_t      x;
    data_t      y;
    data_t      z;
    logic [8:0] s1;
    logic [8:0] s2;
    for (run = 0; run < 2; run++) begin
      // First run forces a carry out of ADD and ADC
      x = (run == 0) ? 8'hC8 : data_t'($urandom);
      y = (run == 0) ? 8'h64 : data_t'($urandom);
      z = (run == 0) ? 8'h9B : data_t'($urandom);
      program_q.delete();
      emit_ldi(REG_A, x);
      emit_ldi(REG_B, y);
      emit_ldi(REG_C, z);
      emit_op(OP_ADD, REG_A, REG_B);
      emit_op(OP_ADC, REG_C, REG_B);
      emit_op(OP_HLT, REG_A, REG_A);
      run_program("add_adc");
      s1 = add_bytes(x, y, 1'b0);
      s2 = add_bytes(z, y, s1[8]);
      check_data("add_adc reg_a", s1[7:0], reg_a);
      check_data("add_adc reg_c", s2[7:0], reg_c);
      check_flags("add_adc flags", {s2[7], s2[8]}, flags);
    end
  endtask

  task automatic test_sub();
    int    run;
    data_t x;
    data_t y;
    data_t diff;
    for (run = 0; run < 4; run++) begin
      x = data_t'($urandom);
      y = (run == 0) ? x : data_t'($urandom);
      program_q.delete();
      emit_ldi(REG_A, x);
      emit_ldi(REG_B, y);
      emit_op(OP_SUB, REG_A, REG_B);
      emit_op(OP_HLT, REG_A, REG_A);
      run_program("sub");
      diff = x - y;
      check_data("sub reg_a", diff, reg_a);
      check_flags("sub flags", {diff[7], x >= y}, flags);
    end
  endtask

  task automatic test_logic();
    int      run;
    opcode_e op;
    data_t   x;
    data_t   y;
    data_t   exp;
    for (run = 0; run < 3; run++) begin
      x = data_t'($urandom);
      y = data_t'($urandom);
      case (run)
        0: begin
          op  = OP_AND;
          exp = x & y;
        end
        1: begin
          op  = OP_OR;
          exp = x | y;
        end
        default: begin
          op  = OP_XOR;
          exp = x ^ y;
        end
      endcase
      program_q.delete();
      emit_ldi(REG_A, x);
      emit_ldi(REG_B, y);
      // FF + 01 leaves carry set before the logic op
      emit_ldi(REG_C, 8'hFF);
      emit_ldi(REG_D, 8'h01);
      emit_op(OP_ADD, REG_C, REG_D);
      emit_op(op, REG_A, REG_B);
      emit_op(OP_HLT, REG_A, REG_A);
      run_program("logic");
      check_data("logic reg_a", exp, reg_a);
      check_flags("logic flags", {exp[7], 1'b0}, flags);
    end
  endtask

  task automatic test_jumps();
    int    to_l1;
    int    to_l2;
    int    to_l3a;
    int    to_l3b;
    int    to_l3c;
    addr_t l3;
    program_q.delete();
    emit_ldi(REG_A, 8'h01);
    to_l1 = emit_jump(OP_JMP);
    emit_ldi(REG_B, 8'hEE);
    patch_target(to_l1, here());
    emit_ldi(REG_C, 8'h80);
    // 80 + 80 sets carry, negative clear
    emit_op(OP_ADD, REG_C, REG_C);
    to_l3a = emit_jump(OP_JN);
    emit_ldi(REG_D, 8'h11);
    to_l2 = emit_jump(OP_JC);
    emit_ldi(REG_B, 8'hEE);
    patch_target(to_l2, here());
    // 00 - 11 sets negative and clears carry
    emit_op(OP_SUB, REG_C, REG_D);
    to_l3b = emit_jump(OP_JC);
    emit_ldi(REG_D, 8'h22);
    to_l3c = emit_jump(OP_JN);
    emit_ldi(REG_A, 8'hEE);
    l3 = here();
    patch_target(to_l3a, l3);
    patch_target(to_l3b, l3);
    patch_target(to_l3c, l3);
    emit_op(OP_HLT, REG_A, REG_A);
    run_program("jumps");
    check_data("jumps reg_a", 8'h01, reg_a);
    check_data("jumps reg_b", 8'h00, reg_b);
    check_data("jumps reg_c", 8'hEF, reg_c);
    check_data("jumps reg_d", 8'h22, reg_d);
    check_flags("jumps flags", 2'b10, flags);
    check_addr("jumps pc", l3 + 16'd1, pc);
  endtask

  task automatic test_chain();
    int         run;
    int         n;
    data_t      x;
    data_t      y;
    data_t      acc;
    logic [8:0] s;
    for (run = 0; run < 2; run++) begin
      x = data_t'($urandom);
      y = data_t'($urandom);
      program_q.delete();
      emit_ldi(REG_A, x);
      emit_ldi(REG_B, y);
      for (n = 0; n < 6; n++) begin
        emit_op(OP_ADD, REG_A, REG_B);
      end
      emit_op(OP_ADC, REG_D, REG_A);
      emit_op(OP_HLT, REG_A, REG_A);
      run_program("chain");
      acc = x;
      s   = '0;
      for (n = 0; n < 6; n++) begin
        s   = add_bytes(acc, y, 1'b0);
        acc = s[7:0];
      end
      // D starts at zero and picks up the last carry
      s = add_bytes(8'h00, acc, s[8]);
      check_data("chain reg_a", acc, reg_a);
      check_data("chain reg_d", s[7:0], reg_d);
      check_flags("chain flags", {s[7], s[8]}, flags);
    end
  endtask

  initial begin
    void'($urandom(32'h7013bb2e));
    rst_n = 1'b0;
    test_ldi_mov();
    test_add_adc();
    test_sub();
    test_logic();
    test_jumps();
    test_chain();
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* build.f */
src/cpu_pkg.sv
src/fetch_if.sv
src/reg_if.sv
src/alu.sv
src/reg_file.sv
src/fetch_unit.sv
src/exec_unit.sv
src/cpu_top.sv
tests/tb_cpu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_cpu -f build.f -o tb_cpu
./obj_dir/tb_cpu
